//--- hw/rv_core_pkg.sv
////////////////////
// RV32I integer subset only, with no M, F or compressed encodings
// Opcodes outside opcode_e retire as no-ops without a register write
////////////////////

package rv_core_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    // Widths with a meaning of their own
    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [4:0]      reg_addr_t;

    // ISA fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    ////////////////////
    // Encodings
    ////////////////////

    // Major opcodes that the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // funct3 of the integer ALU group
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;

endpackage

//--- hw/rv_fetch.sv
`timescale 1ns/100ps

////////////////////
// FETCH_CREDITS is a power of two, at least 2
// PC only increments, there is no redirect
////////////////////

module rv_fetch
    import rv_core_pkg::*;
#(
    parameter addr_t BOOT_ADDR     = '0,
    parameter int    FETCH_CREDITS = 4
) (
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  imem_rsp,
    input  inst_t imem_rdata,
    input  logic  q_pop,
    output logic  imem_req,
    output addr_t imem_addr,
    output logic  q_valid,
    output inst_t q_inst,
    output addr_t q_pc
);

    localparam int PTR_W = $clog2(FETCH_CREDITS);
    localparam int CNT_W = $clog2(FETCH_CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic [CNT_W-1:0] credits_next;
    addr_t            rsp_pc;
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic             q_full;
    inst_t            inst_mem [FETCH_CREDITS];
    addr_t            pc_mem   [FETCH_CREDITS];

    ////////////////////
    // Request side
    ////////////////////

    // One credit per request, one back per word leaving the queue
    assign credits_next = credits - CNT_W'(imem_req) + CNT_W'(q_pop);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            credits   <= CNT_W'(FETCH_CREDITS);
            imem_req  <= 1'b0;
            imem_addr <= BOOT_ADDR;
        end else begin
            credits  <= credits_next;
            // Request in the next cycle only if a credit is left
            imem_req <= (credits_next != '0);
            if (imem_req) begin
                imem_addr <= imem_addr + 32'd4;
            end
        end
    end

    ////////////////////
    // Response queue
    ////////////////////

    // Responses come back in order, so their PC is a second counter
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rsp_pc <= BOOT_ADDR;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (imem_rsp) begin
                rsp_pc <= rsp_pc + 32'd4;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (imem_rsp) begin
            inst_mem[wr_ptr[PTR_W-1:0]] <= imem_rdata;
            pc_mem[wr_ptr[PTR_W-1:0]]   <= rsp_pc;
        end
    end

    assign q_valid = (wr_ptr != rd_ptr);
    assign q_full  = ((wr_ptr ^ rd_ptr) == {1'b1, {PTR_W{1'b0}}});
    assign q_inst  = inst_mem[rd_ptr[PTR_W-1:0]];
    assign q_pc    = pc_mem[rd_ptr[PTR_W-1:0]];

    // Credits bound the words in flight plus the words queued
    a_no_overflow: assert property (
        @(posedge aclk) disable iff (!rst_n) imem_rsp |-> !q_full
    );

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/100ps

////////////////////
// Decodes OP, OP_IMM and LUI, anything else becomes a no-op
////////////////////

module rv_decode
    import rv_core_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      q_valid,
    input  inst_t     q_inst,
    input  addr_t     q_pc,
    input  xlen_t     rs1_val,
    input  xlen_t     rs2_val,
    input  logic      xr_valid,
    input  logic      xr_wr,
    input  reg_addr_t xr_rd,
    output logic      q_pop,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      dx_valid,
    output addr_t     dx_pc,
    output alu_op_e   dx_op,
    output xlen_t     dx_a,
    output xlen_t     dx_b,
    output reg_addr_t dx_rd,
    output logic      dx_wr
);

    opcode_e   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    xlen_t     imm_i;
    xlen_t     imm_u;
    alu_op_e   op;
    xlen_t     op_b;
    logic      use_rs1;
    logic      use_rs2;
    logic      wr_en;
    logic      raw_rs1;
    logic      raw_rs2;

    function automatic alu_op_e alu_sel(funct3_t f3, logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Instruction fields
    assign opcode   = opcode_e'(q_inst[6:0]);
    assign rd       = q_inst[11:7];
    assign funct3   = q_inst[14:12];
    assign rs1_addr = q_inst[19:15];
    assign rs2_addr = q_inst[24:20];
    assign funct7   = q_inst[31:25];
    assign imm_i    = {{20{q_inst[31]}}, q_inst[31:20]};
    assign imm_u    = {q_inst[31:12], 12'b0};

    always_comb begin
        op      = ALU_ADD;
        op_b    = imm_i;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        wr_en   = 1'b0;
        case (opcode)
            OPC_OP: begin
                op      = alu_sel(funct3, funct7[5]);
                op_b    = rs2_val;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wr_en   = 1'b1;
            end
            OPC_OP_IMM: begin
                // No SUBI, funct7 only selects SRAI
                op      = alu_sel(funct3, (funct3 == F3_SR) && funct7[5]);
                use_rs1 = 1'b1;
                wr_en   = 1'b1;
            end
            OPC_LUI: begin
                op    = ALU_PASS_B;
                op_b  = imm_u;
                wr_en = 1'b1;
            end
            default: begin
            end
        endcase
        if (rd == '0) begin
            wr_en = 1'b0;
        end
    end

    ////////////////////
    // Hazard stall
    ////////////////////

    // Wait until a pending write to a source register reaches the file
    assign raw_rs1 = use_rs1 && (rs1_addr != '0)
                   && ((dx_valid && dx_wr && (dx_rd == rs1_addr))
                    || (xr_valid && xr_wr && (xr_rd == rs1_addr)));
    assign raw_rs2 = use_rs2 && (rs2_addr != '0)
                   && ((dx_valid && dx_wr && (dx_rd == rs2_addr))
                    || (xr_valid && xr_wr && (xr_rd == rs2_addr)));

    assign q_pop = q_valid && !(raw_rs1 || raw_rs2);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            dx_valid <= 1'b0;
            dx_wr    <= 1'b0;
        end else begin
            dx_valid <= q_pop;
            dx_wr    <= q_pop && wr_en;
        end
    end

    always_ff @(posedge aclk) begin
        if (q_pop) begin
            dx_pc <= q_pc;
            dx_op <= op;
            dx_a  <= rs1_val;
            dx_b  <= op_b;
            dx_rd <= rd;
        end
    end

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/100ps

////////////////////
// Single-cycle ALU, shift amount is the low 5 bits of operand b
////////////////////

module rv_execute
    import rv_core_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      dx_valid,
    input  addr_t     dx_pc,
    input  alu_op_e   dx_op,
    input  xlen_t     dx_a,
    input  xlen_t     dx_b,
    input  reg_addr_t dx_rd,
    input  logic      dx_wr,
    output logic      xr_valid,
    output addr_t     xr_pc,
    output reg_addr_t xr_rd,
    output logic      xr_wr,
    output xlen_t     xr_val
);

    xlen_t      alu_res;
    logic [4:0] shamt;

    assign shamt = dx_b[4:0];

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        case (dx_op)
            ALU_ADD:    alu_res = dx_a + dx_b;
            ALU_SUB:    alu_res = dx_a - dx_b;
            ALU_AND:    alu_res = dx_a & dx_b;
            ALU_OR:     alu_res = dx_a | dx_b;
            ALU_XOR:    alu_res = dx_a ^ dx_b;
            ALU_SLT:    alu_res = {31'b0, $signed(dx_a) < $signed(dx_b)};
            ALU_SLTU:   alu_res = {31'b0, dx_a < dx_b};
            ALU_SLL:    alu_res = dx_a << shamt;
            ALU_SRL:    alu_res = dx_a >> shamt;
            ALU_SRA:    alu_res = xlen_t'($signed(dx_a) >>> shamt);
            ALU_PASS_B: alu_res = dx_b;
            default:    alu_res = '0;
        endcase
    end

    // Result stage register
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            xr_valid <= 1'b0;
            xr_wr    <= 1'b0;
        end else begin
            xr_valid <= dx_valid;
            xr_wr    <= dx_valid && dx_wr;
        end
    end

    always_ff @(posedge aclk) begin
        if (dx_valid) begin
            xr_pc  <= dx_pc;
            xr_rd  <= dx_rd;
            xr_val <= alu_res;
        end
    end

    // Decode only ever issues a known operation
    a_legal_op: assert property (
        @(posedge aclk) disable iff (!rst_n)
        dx_valid |-> (dx_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
                                    ALU_PASS_B})
    );

endmodule

//--- hw/rv_result.sv
`timescale 1ns/100ps

////////////////////
// Reads are combinational, a write lands at the end of the retire cycle
////////////////////

module rv_result
    import rv_core_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      xr_valid,
    input  addr_t     xr_pc,
    input  reg_addr_t xr_rd,
    input  logic      xr_wr,
    input  xlen_t     xr_val,
    output xlen_t     rs1_val,
    output xlen_t     rs2_val,
    output logic      retire_valid,
    output addr_t     retire_pc,
    output logic      retire_wr,
    output reg_addr_t retire_rd,
    output xlen_t     retire_val
);

    // x0 has no storage
    xlen_t regs [1:31];
    logic  wr_en;

    assign wr_en = xr_valid && xr_wr && (xr_rd != '0);

    ////////////////////
    // Register file
    ////////////////////

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[xr_rd] <= xr_val;
        end
    end

    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    ////////////////////
    // Retire port
    ////////////////////

    // Retire mirrors the result stage register, same edge as the write
    assign retire_valid = xr_valid;
    assign retire_pc    = xr_pc;
    assign retire_wr    = xr_valid && xr_wr;
    assign retire_rd    = xr_rd;
    assign retire_val   = xr_val;

    // Decode drops writes to x0 before they enter the pipe
    a_retire_wr_rd: assert property (
        @(posedge aclk) disable iff (!rst_n)
        retire_wr |-> (retire_rd != '0)
    );

endmodule

//--- hw/rv_core.sv
`timescale 1ns/100ps

////////////////////
// FETCH_CREDITS must be a power of two, at least 2
// The memory accepts every request and answers in order
////////////////////

module rv_core
    import rv_core_pkg::*;
#(
    parameter addr_t BOOT_ADDR     = '0,
    parameter int    FETCH_CREDITS = 4
) (
    input  logic      aclk,
    input  logic      rst_n,
    // Instruction memory
    output logic      imem_req,
    output addr_t     imem_addr,
    input  logic      imem_rsp,
    input  inst_t     imem_rdata,
    // Retire port
    output logic      retire_valid,
    output addr_t     retire_pc,
    output logic      retire_wr,
    output reg_addr_t retire_rd,
    output xlen_t     retire_val
);

    // Fetch queue head
    logic      q_valid;
    inst_t     q_inst;
    addr_t     q_pc;
    logic      q_pop;

    // Register reads
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_val;
    xlen_t     rs2_val;

    // Decode to execute
    logic      dx_valid;
    addr_t     dx_pc;
    alu_op_e   dx_op;
    xlen_t     dx_a;
    xlen_t     dx_b;
    reg_addr_t dx_rd;
    logic      dx_wr;

    // Execute to result
    logic      xr_valid;
    addr_t     xr_pc;
    reg_addr_t xr_rd;
    logic      xr_wr;
    xlen_t     xr_val;

    rv_fetch #(
        .BOOT_ADDR     (BOOT_ADDR),
        .FETCH_CREDITS (FETCH_CREDITS)
    ) u_rv_fetch (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .imem_rsp   (imem_rsp),
        .imem_rdata (imem_rdata),
        .q_pop      (q_pop),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .q_valid    (q_valid),
        .q_inst     (q_inst),
        .q_pc       (q_pc)
    );

    rv_decode u_rv_decode (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .q_valid  (q_valid),
        .q_inst   (q_inst),
        .q_pc     (q_pc),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .xr_valid (xr_valid),
        .xr_wr    (xr_wr),
        .xr_rd    (xr_rd),
        .q_pop    (q_pop),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .dx_valid (dx_valid),
        .dx_pc    (dx_pc),
        .dx_op    (dx_op),
        .dx_a     (dx_a),
        .dx_b     (dx_b),
        .dx_rd    (dx_rd),
        .dx_wr    (dx_wr)
    );

    rv_execute u_rv_execute (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .dx_valid (dx_valid),
        .dx_pc    (dx_pc),
        .dx_op    (dx_op),
        .dx_a     (dx_a),
        .dx_b     (dx_b),
        .dx_rd    (dx_rd),
        .dx_wr    (dx_wr),
        .xr_valid (xr_valid),
        .xr_pc    (xr_pc),
        .xr_rd    (xr_rd),
        .xr_wr    (xr_wr),
        .xr_val   (xr_val)
    );

    rv_result u_rv_result (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .xr_valid     (xr_valid),
        .xr_pc        (xr_pc),
        .xr_rd        (xr_rd),
        .xr_wr        (xr_wr),
        .xr_val       (xr_val),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wr    (retire_wr),
        .retire_rd    (retire_rd),
        .retire_val   (retire_val)
    );

endmodule

//--- tests/imem_model.sv
`timescale 1ns/100ps

////////////////////
// Accepts every request and answers in order after 1 to 6 cycles
// Word index is the byte address over 4, so the program sits at address 0
////////////////////

module imem_model
    import rv_core_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  imem_req,
    input  addr_t imem_addr,
    output logic  imem_rsp,
    output inst_t imem_rdata
);

    localparam logic [31:0] LFSR_SEED = 32'h7a4b2852;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;

    inst_t       prog [int];
    logic [31:0] lfsr;
    int          cycle;
    addr_t       pend_addr [$];
    int          pend_due  [$];

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] draw(int n);
        logic [31:0] val;
        logic        bit_out;
        val = '0;
        for (int k = 0; k < n; k++) begin
            bit_out = lfsr[0];
            lfsr    = (lfsr >> 1) ^ (bit_out ? LFSR_POLY : 32'h0);
            val     = {val[30:0], bit_out};
        end
        return val;
    endfunction

    function automatic inst_t read_word(addr_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (prog.exists(idx)) begin
            return prog[idx];
        end
        // Past the program, custom-0 words that carry the address
        return {addr[31:7] ^ addr[24:0], 7'b0001011};
    endfunction

    task automatic load_word(int idx, inst_t word);
        prog[idx] = word;
    endtask

    initial begin
        lfsr       = LFSR_SEED;
        cycle      = 0;
        imem_rsp   = 1'b0;
        imem_rdata = NOP_INST;
    end

    always @(posedge aclk) begin
        if (!rst_n) begin
            imem_rsp <= 1'b0;
            pend_addr.delete();
            pend_due.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (imem_req) begin
                pend_addr.push_back(imem_addr);
                pend_due.push_back(cycle + int'(draw(3) % 6));
            end
            imem_rsp <= 1'b0;
            // Only the oldest request may answer, which keeps the order
            if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
                imem_rsp   <= 1'b1;
                imem_rdata <= read_word(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
        end
    end

endmodule

//--- tests/rv_core_tb.sv
`timescale 1ns/100ps

////////////////////
// DUT runs with default parameters, BOOT_ADDR 0 and four fetch credits
// Expected results come from an ISA-level model of the register file
////////////////////

module rv_core_tb
    import rv_core_pkg::*;
();

    localparam int          PROG_LEN   = 200;
    localparam int          MAX_CYCLES = PROG_LEN * 8 + 100;
    localparam int          CREDITS    = 4;
    localparam addr_t       BOOT_ADDR  = '0;
    localparam logic [31:0] LFSR_SEED  = 32'h7a4b2852;
    localparam logic [31:0] LFSR_POLY  = 32'h80200003;

    logic      aclk;
    logic      rst_n;
    logic      imem_req;
    addr_t     imem_addr;
    logic      imem_rsp;
    inst_t     imem_rdata;
    logic      retire_valid;
    addr_t     retire_pc;
    logic      retire_wr;
    reg_addr_t retire_rd;
    xlen_t     retire_val;

    // Expected retire stream in program order
    logic      exp_wr  [PROG_LEN];
    reg_addr_t exp_rd  [PROG_LEN];
    xlen_t     exp_val [PROG_LEN];

    logic [31:0] lfsr;
    int          mismatches = 0;
    int          faults     = 0;
    int          retired    = 0;
    int          edges      = 0;
    int          in_flight  = 0;
    addr_t       req_addr   = '0;

    rv_core u_rv_core (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_rsp     (imem_rsp),
        .imem_rdata   (imem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wr    (retire_wr),
        .retire_rd    (retire_rd),
        .retire_val   (retire_val)
    );

    imem_model u_imem_model (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_rsp   (imem_rsp),
        .imem_rdata (imem_rdata)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] draw(int n);
        logic [31:0] val;
        logic        bit_out;
        val = '0;
        for (int k = 0; k < n; k++) begin
            bit_out = lfsr[0];
            lfsr    = (lfsr >> 1) ^ (bit_out ? LFSR_POLY : 32'h0);
            val     = {val[30:0], bit_out};
        end
        return val;
    endfunction

    // Mostly x0 to x3 so that dependent pairs are common
    function automatic reg_addr_t pick_reg();
        logic [2:0] sel;
        sel = 3'(draw(3));
        if (sel < 3'd6) begin
            return reg_addr_t'(sel[1:0]);
        end
        return reg_addr_t'(draw(5));
    endfunction

    // RV32I integer ALU group by funct3, alt is instruction bit 30
    function automatic xlen_t ref_alu(funct3_t f3, logic alt, xlen_t a, xlen_t b);
        xlen_t sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? sra : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic log_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("FAILED at %0t: %s got %h expected %h", $time, sig, got, exp);
        mismatches++;
    endtask

    task automatic raise_fault(string what);
        $display("Error at %0t: %s", $time, what);
        faults++;
    endtask

    ////////////////////
    // Program and reference model
    ////////////////////

    task automatic build_program();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        funct3_t     f3;
        logic        alt;
        logic        writes;
        logic [3:0]  kind;
        logic [11:0] imm;
        logic [6:0]  bad_opc;
        inst_t       word;
        xlen_t       res;
        xlen_t       regs_ref [32];
        lfsr = LFSR_SEED;
        for (int r = 0; r < 32; r++) begin
            regs_ref[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind   = 4'(draw(4));
            rd     = pick_reg();
            rs1    = pick_reg();
            rs2    = pick_reg();
            f3     = funct3_t'(draw(3));
            alt    = 1'b0;
            writes = 1'b1;
            res    = '0;
            if (kind < 4'd6) begin
                if (f3 == 3'b000 || f3 == 3'b101) begin
                    alt = 1'(draw(1));
                end
                word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
                res  = ref_alu(f3, alt, regs_ref[rs1], regs_ref[rs2]);
            end else if (kind < 4'd11) begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    alt = (f3 == 3'b101) ? 1'(draw(1)) : 1'b0;
                    imm = {1'b0, alt, 5'b0, 5'(draw(5))};
                end else begin
                    imm = 12'(draw(12));
                end
                word = {imm, rs1, f3, rd, OPC_OP_IMM};
                res  = ref_alu(f3, alt, regs_ref[rs1], {{20{imm[11]}}, imm});
            end else if (kind < 4'd14) begin
                word = {20'(draw(20)), rd, OPC_LUI};
                res  = {word[31:12], 12'b0};
            end else begin
                // Load, store, branch and AUIPC words are not executed
                case (2'(draw(2)))
                    2'd0:    bad_opc = 7'b0000011;
                    2'd1:    bad_opc = 7'b0100011;
                    2'd2:    bad_opc = 7'b1100011;
                    default: bad_opc = 7'b0010111;
                endcase
                word   = {25'(draw(25)), bad_opc};
                writes = 1'b0;
            end
            if (rd == '0) begin
                writes = 1'b0;
            end
            if (writes) begin
                regs_ref[rd] = res;
            end
            exp_wr[i]  = writes;
            exp_rd[i]  = rd;
            exp_val[i] = res;
            u_imem_model.load_word(i, word);
        end
    endtask

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_retire(int idx);
        addr_t pc;
        pc = BOOT_ADDR + addr_t'(idx * 4);
        assert (retire_pc == pc) else log_mismatch("retire_pc", retire_pc, pc);
        if (idx < PROG_LEN) begin
            assert (retire_wr == exp_wr[idx])
                else log_mismatch("retire_wr", 32'(retire_wr), 32'(exp_wr[idx]));
            if (exp_wr[idx]) begin
                assert (retire_rd == exp_rd[idx])
                    else log_mismatch("retire_rd", 32'(retire_rd), 32'(exp_rd[idx]));
                assert (retire_val == exp_val[idx])
                    else log_mismatch("retire_val", retire_val, exp_val[idx]);
            end
        end else begin
            assert (!retire_wr) else raise_fault("a word past the program wrote a register");
        end
    endtask

    always @(posedge aclk) begin : monitor
        edges++;
        if (!rst_n) begin
            // DUT registers are unknown until the first reset edge
            if (edges > 1) begin
                assert (!imem_req) else raise_fault("imem_req high during reset");
                assert (!retire_valid) else raise_fault("retire_valid high during reset");
            end
            in_flight = 0;
            req_addr  = BOOT_ADDR;
        end else begin
            if (imem_req) begin
                assert (imem_addr == req_addr)
                    else log_mismatch("imem_addr", imem_addr, req_addr);
                req_addr = req_addr + 32'd4;
            end
            in_flight = in_flight + int'(imem_req) - int'(imem_rsp);
            assert (in_flight <= CREDITS) else raise_fault("more fetches in flight than credits");
            if (retire_valid) begin
                check_retire(retired);
                retired <= retired + 1;
            end
        end
    end

    initial begin : control
        int cycles;
        cycles = 0;
        rst_n  = 1'b0;
        build_program();
        repeat (3) @(posedge aclk);
        rst_n <= 1'b1;
        while (retired < PROG_LEN && cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        @(negedge aclk);
        if (retired < PROG_LEN) begin
            raise_fault($sformatf("timeout, only %0d of %0d instructions retired",
                                  retired, PROG_LEN));
        end
        $display("Done after %0d cycles: %0d mismatches, %0d other errors, %0d retired",
                 cycles, mismatches, faults, retired);
        if (mismatches == 0 && faults == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/rv_core_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
tests/imem_model.sv
tests/rv_core_tb.sv

//--- Makefile
# Verilator build and run for the rv_core testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := rv_core_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
PASS_MSG := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
